//--- build.f
logic/pcie_rst_pkg.sv
logic/rst_input_sync.sv
logic/lock_qualifier.sv
logic/serdes_rst_seq.sv
logic/core_rst_gen.sv
logic/pcie_rst_ctrl.sv
sim/tb_pcie_rst_ctrl.sv

//--- logic/core_rst_gen.sv
`timescale 1ns/1ps

module core_rst_gen (
   input  logic                      pld_clk,
   input  logic                      arst,
   input  pcie_rst_pkg::link_event_t link,
   output logic                      crst,
   output logic                      srst
);

   import pcie_rst_pkg::*;

   logic      exits_q;
   core_cnt_t rst_cnt;
   logic      crst_src;
   logic      srst_src;

   // any active-low exit strobe, or the link parked in disabled
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         exits_q <= 1'b0;
      end else begin
         exits_q <= !link.dlup_exit ||
                    !link.hotrst_exit ||
                    !link.l2_exit ||
                    (link.ltssm == ltssm_disabled);
      end
   end

   //////////////////////////////
   // reset counter
   //////////////////////////////

   // an exit only restarts the tail end of the count
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         rst_cnt <= '0;
      end else if (exits_q) begin
         rst_cnt <= core_rst_exit_reload;
      end else if (rst_cnt != core_rst_count_max) begin
         rst_cnt <= rst_cnt + core_cnt_t'(1);
      end
   end

   // source flops
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         crst_src <= 1'b1;
         srst_src <= 1'b1;
      end else if (exits_q) begin
         crst_src <= 1'b1;
         srst_src <= 1'b1;
      end else if (rst_cnt == core_rst_count_max) begin
         crst_src <= 1'b0;
         srst_src <= 1'b0;
      end
   end

   // output stage
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         crst <= 1'b1;
         srst <= 1'b1;
      end else begin
         crst <= crst_src;
         srst <= srst_src;
      end
   end

endmodule

//--- logic/lock_qualifier.sv
`timescale 1ns/1ps

module lock_qualifier (
   input  logic                       pld_clk,
   input  logic                       arst,
   input  pcie_rst_pkg::xcvr_status_t status,
   output pcie_rst_pkg::lock_state_t  lock
);

   import pcie_rst_pkg::*;

   pll_cnt_t  pll_cnt;
   lane_vec_t rx_pll_sticky;
   logic      lanes_ok;
   hold_cnt_t hold_cnt;

   //////////////////////////////
   // tx pll stability
   //////////////////////////////

   // count while locked, any drop starts over
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         pll_cnt         <= '0;
         lock.pll_locked <= 1'b0;
         lock.pll_stable <= 1'b0;
      end else begin
         if (!status.pll_locked) begin
            pll_cnt <= '0;
         end else if (pll_cnt < pll_stable_cycles) begin
            pll_cnt <= pll_cnt + pll_cnt_t'(1);
         end
         lock.pll_locked <= status.pll_locked;
         // gating with the live lock drops stable one cycle after the loss
         lock.pll_stable <= status.pll_locked && (pll_cnt == pll_stable_cycles);
      end
   end

   //////////////////////////////
   // rx lock with hysteresis
   //////////////////////////////

   // sticky once every lane pll has locked
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         rx_pll_sticky <= '0;
      end else if (&status.rx_pll_locked) begin
         rx_pll_sticky <= '1;
      end
   end

   assign lanes_ok = &(rx_pll_sticky | status.rx_freqlocked);

   // reload on good lock, bleed down on loss
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         hold_cnt       <= '0;
         lock.rx_locked <= 1'b0;
      end else begin
         if (lanes_ok) begin
            hold_cnt <= rx_lock_hold_cycles;
         end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - hold_cnt_t'(1);
         end
         lock.rx_locked <= (hold_cnt != '0);
      end
   end

   // calibration and fifo status, one register
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         lock.tx_cal_busy <= 1'b1;
         lock.rx_cal_busy <= 1'b1;
         lock.fifo_err    <= 1'b0;
      end else begin
         lock.tx_cal_busy <= status.tx_cal_busy;
         lock.rx_cal_busy <= status.rx_cal_busy;
         lock.fifo_err    <= status.fifo_err;
      end
   end

endmodule

//--- logic/pcie_rst_ctrl.sv
`timescale 1ns/1ps

module pcie_rst_ctrl #(
   parameter int unsigned ws_long_cycles = pcie_rst_pkg::ws_long_default
) (
   input  logic                    pld_clk,
   input  logic                    arst,
   input  logic                    pll_locked,
   input  pcie_rst_pkg::lane_vec_t rx_pll_locked,
   input  pcie_rst_pkg::lane_vec_t rx_freqlocked,
   input  logic                    tx_cal_busy,
   input  logic                    rx_cal_busy,
   input  logic                    fifo_err,
   input  pcie_rst_pkg::ltssm_t    ltssm,
   input  logic                    dlup_exit,
   input  logic                    hotrst_exit,
   input  logic                    l2_exit,
   output logic                    crst,
   output logic                    srst,
   output logic                    txdigitalreset,
   output logic                    rxanalogreset,
   output logic                    rxdigitalreset
);

   import pcie_rst_pkg::*;

   xcvr_status_t status;
   link_event_t  link;
   lock_state_t  lock;
   serdes_rst_t  serdes_rst;

   // sync stage feeds both the lock path and the core reset path
   rst_input_sync u_rst_input_sync (
      .pld_clk       (pld_clk),
      .arst          (arst),
      .pll_locked    (pll_locked),
      .rx_pll_locked (rx_pll_locked),
      .rx_freqlocked (rx_freqlocked),
      .tx_cal_busy   (tx_cal_busy),
      .rx_cal_busy   (rx_cal_busy),
      .fifo_err      (fifo_err),
      .ltssm         (ltssm),
      .dlup_exit     (dlup_exit),
      .hotrst_exit   (hotrst_exit),
      .l2_exit       (l2_exit),
      .status        (status),
      .link          (link)
   );

   lock_qualifier u_lock_qualifier (
      .pld_clk (pld_clk),
      .arst    (arst),
      .status  (status),
      .lock    (lock)
   );

   serdes_rst_seq #(
      .ws_long_cycles (ws_long_cycles)
   ) u_serdes_rst_seq (
      .pld_clk (pld_clk),
      .arst    (arst),
      .lock    (lock),
      .rst     (serdes_rst)
   );

   core_rst_gen u_core_rst_gen (
      .pld_clk (pld_clk),
      .arst    (arst),
      .link    (link),
      .crst    (crst),
      .srst    (srst)
   );

   // transceiver resets leave as discrete pins
   assign txdigitalreset = serdes_rst.tx_digital;
   assign rxanalogreset  = serdes_rst.rx_analog;
   assign rxdigitalreset = serdes_rst.rx_digital;

endmodule

//--- logic/pcie_rst_pkg.sv
package pcie_rst_pkg;

   //////////////////////////////
   // widths and counts
   //////////////////////////////

   localparam int lane_count  = 8;
   localparam int sync_stages = 3;

   typedef logic [lane_count-1:0] lane_vec_t;
   typedef logic [4:0]            ltssm_t;
   typedef logic [6:0]            pll_cnt_t;
   typedef logic [2:0]            hold_cnt_t;
   typedef logic [19:0]           ws_timer_t;
   typedef logic [10:0]           core_cnt_t;

   // ltssm codes of interest
   localparam ltssm_t ltssm_detect_quiet  = 5'h00;
   localparam ltssm_t ltssm_detect_active = 5'h01;
   localparam ltssm_t ltssm_disabled      = 5'h10;

   // lock qualification
   localparam pll_cnt_t  pll_stable_cycles   = 7'd127;
   localparam hold_cnt_t rx_lock_hold_cycles = 3'd7;

   // wait timer, long value is roughly 1 ms at 125 MHz
   localparam int unsigned ws_long_default = 125000;
   localparam ws_timer_t   ws_short_cycles = 20'd32;

   // core reset counter
   localparam core_cnt_t core_rst_count_max   = 11'd1024;
   localparam core_cnt_t core_rst_exit_reload = 11'h3f0;

   //////////////////////////////
   // stage payloads
   //////////////////////////////

   typedef struct packed {
      logic      pll_locked;
      lane_vec_t rx_pll_locked;
      lane_vec_t rx_freqlocked;
      logic      tx_cal_busy;
      logic      rx_cal_busy;
      logic      fifo_err;
   } xcvr_status_t;

   typedef struct packed {
      logic pll_locked;
      logic pll_stable;
      logic rx_locked;
      logic tx_cal_busy;
      logic rx_cal_busy;
      logic fifo_err;
   } lock_state_t;

   // exit strobes are active low
   typedef struct packed {
      ltssm_t ltssm;
      logic   dlup_exit;
      logic   hotrst_exit;
      logic   l2_exit;
   } link_event_t;

   typedef struct packed {
      logic tx_digital;
      logic rx_analog;
      logic rx_digital;
   } serdes_rst_t;

   typedef enum logic [1:0] {
      wait_tx_pll    = 2'b00,
      run            = 2'b01,
      wait_rx_lock   = 2'b10,
      wait_rx_settle = 2'b11
   } serdes_state_t;

endpackage

//--- logic/rst_input_sync.sv
`timescale 1ns/1ps

module rst_input_sync (
   input  logic                      pld_clk,
   input  logic                      arst,
   input  logic                      pll_locked,
   input  pcie_rst_pkg::lane_vec_t   rx_pll_locked,
   input  pcie_rst_pkg::lane_vec_t   rx_freqlocked,
   input  logic                      tx_cal_busy,
   input  logic                      rx_cal_busy,
   input  logic                      fifo_err,
   input  pcie_rst_pkg::ltssm_t      ltssm,
   input  logic                      dlup_exit,
   input  logic                      hotrst_exit,
   input  logic                      l2_exit,
   output pcie_rst_pkg::xcvr_status_t status,
   output pcie_rst_pkg::link_event_t  link
);

   import pcie_rst_pkg::*;

   xcvr_status_t                    raw;
   xcvr_status_t [sync_stages-1:0]  sync_q;

   // gather the asynchronous transceiver status into one word
   always_comb begin
      raw.pll_locked    = pll_locked;
      raw.rx_pll_locked = rx_pll_locked;
      raw.rx_freqlocked = rx_freqlocked;
      raw.tx_cal_busy   = tx_cal_busy;
      raw.rx_cal_busy   = rx_cal_busy;
      raw.fifo_err      = fifo_err;
   end

   // flop chain, every bit resynchronized on its own
   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[sync_stages-2:0], raw};
      end
   end

   assign status = sync_q[sync_stages-1];

   //////////////////////////////
   // link events, already on pld_clk
   //////////////////////////////

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         link.ltssm       <= ltssm_detect_quiet;
         link.dlup_exit   <= 1'b1;
         link.hotrst_exit <= 1'b1;
         link.l2_exit     <= 1'b1;
      end else begin
         link.ltssm       <= ltssm;
         link.dlup_exit   <= dlup_exit;
         link.hotrst_exit <= hotrst_exit;
         link.l2_exit     <= l2_exit;
      end
   end

endmodule

//--- logic/serdes_rst_seq.sv
`timescale 1ns/1ps

module serdes_rst_seq #(
   parameter int unsigned ws_long_cycles = pcie_rst_pkg::ws_long_default
) (
   input  logic                      pld_clk,
   input  logic                      arst,
   input  pcie_rst_pkg::lock_state_t lock,
   output pcie_rst_pkg::serdes_rst_t rst
);

   import pcie_rst_pkg::*;

   serdes_state_t state;
   ws_timer_t     ws_timer;
   logic          ld_long;
   logic          ld_short;
   logic          ws_expired;

   //////////////////////////////
   // wait timer
   //////////////////////////////

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         ws_timer   <= '1;
         ws_expired <= 1'b0;
      end else begin
         if (ld_long) begin
            ws_timer <= ws_timer_t'(ws_long_cycles);
         end else if (ld_short) begin
            ws_timer <= ws_short_cycles;
         end else if (ws_timer != '0) begin
            ws_timer <= ws_timer - ws_timer_t'(1);
         end
         // a pending load hides the old zero
         ws_expired <= !(ld_long || ld_short) && (ws_timer == '0);
      end
   end

   //////////////////////////////
   // reset sequencing FSM
   //////////////////////////////

   always_ff @(posedge pld_clk or posedge arst) begin
      if (arst) begin
         state    <= wait_tx_pll;
         ld_long  <= 1'b1;
         ld_short <= 1'b0;
         rst      <= '1;
      end else begin
         // timer loads last one cycle
         ld_long  <= 1'b0;
         ld_short <= 1'b0;

         case (state)
            wait_tx_pll: begin
               // ws_expired still holds the stale zero while the long load is pending
               if (lock.pll_locked && lock.pll_stable && !ld_long && ws_expired) begin
                  rst.tx_digital <= lock.tx_cal_busy;
                  rst.rx_analog  <= lock.rx_cal_busy;
                  rst.rx_digital <= 1'b1;
                  if (!lock.rx_cal_busy) begin
                     state <= wait_rx_lock;
                  end
               end else begin
                  rst <= '1;
               end
            end

            wait_rx_lock: begin
               rst.tx_digital <= 1'b0;
               rst.rx_analog  <= 1'b0;
               rst.rx_digital <= 1'b1;
               if (lock.rx_locked) begin
                  ld_short <= 1'b1;
                  state    <= wait_rx_settle;
               end
            end

            wait_rx_settle: begin
               if (!lock.rx_locked) begin
                  rst.rx_digital <= 1'b1;
                  state          <= wait_rx_lock;
               end else if (!ld_short && ws_expired) begin
                  rst.rx_digital <= 1'b0;
                  state          <= run;
               end
            end

            run: begin
               if (!lock.rx_locked) begin
                  // full restart from the tx pll
                  rst     <= '1;
                  ld_long <= 1'b1;
                  state   <= wait_tx_pll;
               end else if (lock.fifo_err) begin
                  rst.rx_digital <= 1'b1;
                  state          <= wait_rx_lock;
               end
            end

            default: begin
               rst   <= '1;
               state <= wait_tx_pll;
            end
         endcase
      end
   end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the reset controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f build.f \
   --top-module tb_pcie_rst_ctrl \
   -Mdir obj_dir

./obj_dir/Vtb_pcie_rst_ctrl | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
echo "simulation passed"

//--- sim/pcie_rst_trace.txt
# hold pll rx_pll freq tx_cal rx_cal fifo ltssm dlup hotrst l2 flicker, then crst srst txd rxa rxd
# inputs in hex, hold in cycles, expected outputs 0, 1 or - for don't care
1    0 00 00 0 0 0 00 1 1 1 0  1 1 1 1 1
999  0 00 00 0 0 0 00 1 1 1 0  1 1 1 1 1
100  0 00 00 0 0 0 00 1 1 1 0  0 0 1 1 1
300  1 7f 00 1 1 0 00 1 1 1 0  0 0 1 1 1
50   1 7f 00 0 1 0 00 1 1 1 0  0 0 0 1 1
50   1 7f 00 0 0 0 00 1 1 1 0  0 0 0 0 1
60   1 7f ff 0 0 0 01 1 1 1 0  0 0 0 0 0
20   1 7f 00 0 0 0 01 1 1 1 0  0 0 - - 1
200  1 7f 00 0 0 0 01 1 1 1 0  0 0 0 0 1
60   1 7f ff 0 0 0 01 1 1 1 0  0 0 0 0 0
150  1 7f ff 0 0 0 01 1 1 1 1  0 0 0 0 0
120  1 7f ff 0 0 0 01 1 1 1 1  0 0 0 0 0
2    1 7f ff 0 0 1 01 1 1 1 0  0 0 0 0 -
8    1 7f ff 0 0 0 01 1 1 1 0  0 0 0 0 1
60   1 7f ff 0 0 0 01 1 1 1 0  0 0 0 0 0
1    1 7f ff 0 0 0 01 1 1 0 0  - - 0 0 0
4    1 7f ff 0 0 0 01 1 1 1 0  1 1 0 0 0
10   1 7f ff 0 0 0 01 1 1 1 0  1 1 0 0 0
30   1 7f ff 0 0 0 01 1 1 1 0  0 0 0 0 0
5    1 7f ff 0 0 0 10 1 1 1 0  1 1 0 0 0
100  1 7f ff 0 0 0 10 1 1 1 0  1 1 0 0 0
40   1 7f ff 0 0 0 01 1 1 1 0  0 0 0 0 0
1    1 7f ff 0 0 0 01 1 0 1 0  - - 0 0 0
4    1 7f ff 0 0 0 01 1 1 1 0  1 1 0 0 0
40   1 7f ff 0 0 0 01 1 1 1 0  0 0 0 0 0

//--- sim/tb_pcie_rst_ctrl.sv
`timescale 1ns/1ps

module tb_pcie_rst_ctrl;

   import pcie_rst_pkg::*;

   // one trace line with the expected outputs kept as characters 0, 1 or -
   typedef struct packed {
      int unsigned hold;
      logic        pll_locked;
      lane_vec_t   rx_pll_locked;
      lane_vec_t   rx_freqlocked;
      logic        tx_cal_busy;
      logic        rx_cal_busy;
      logic        fifo_err;
      ltssm_t      ltssm;
      logic        dlup_exit;
      logic        hotrst_exit;
      logic        l2_exit;
      logic        flicker;
      logic [7:0]  exp_crst;
      logic [7:0]  exp_srst;
      logic [7:0]  exp_txd;
      logic [7:0]  exp_rxa;
      logic [7:0]  exp_rxd;
   } trace_step_t;

   logic      pld_clk;
   logic      arst;
   logic      pll_locked;
   lane_vec_t rx_pll_locked;
   lane_vec_t rx_freqlocked;
   logic      tx_cal_busy;
   logic      rx_cal_busy;
   logic      fifo_err;
   ltssm_t    ltssm;
   logic      dlup_exit;
   logic      hotrst_exit;
   logic      l2_exit;
   logic      crst;
   logic      srst;
   logic      txdigitalreset;
   logic      rxanalogreset;
   logic      rxdigitalreset;

   trace_step_t steps[$];
   int          checks;
   int          errors;
   int unsigned total_cycles;
   logic        trace_loaded = 1'b0;

   pcie_rst_ctrl #(
      .ws_long_cycles (64)
   ) u_pcie_rst_ctrl (
      .pld_clk        (pld_clk),
      .arst           (arst),
      .pll_locked     (pll_locked),
      .rx_pll_locked  (rx_pll_locked),
      .rx_freqlocked  (rx_freqlocked),
      .tx_cal_busy    (tx_cal_busy),
      .rx_cal_busy    (rx_cal_busy),
      .fifo_err       (fifo_err),
      .ltssm          (ltssm),
      .dlup_exit      (dlup_exit),
      .hotrst_exit    (hotrst_exit),
      .l2_exit        (l2_exit),
      .crst           (crst),
      .srst           (srst),
      .txdigitalreset (txdigitalreset),
      .rxanalogreset  (rxanalogreset),
      .rxdigitalreset (rxdigitalreset)
   );

   initial begin
      pld_clk = 1'b0;
      forever #4 pld_clk = ~pld_clk;
   end

   // watchdog sized from the trace length
   initial begin
      wait (trace_loaded);
      #(total_cycles * 8 + 2000);
      $display("timeout: the trace did not complete before the watchdog expired");
      $display("SOME TESTS FAILED");
      $finish;
   end

   task automatic load_trace();
      int          fd;
      int          n;
      string       line;
      int unsigned hold_v;
      logic [31:0] c_pll, c_rxpll, c_freq, c_txcal, c_rxcal, c_fifo;
      logic [31:0] c_ltssm, c_dlup, c_hot, c_l2, c_flick;
      logic [7:0]  s_crst, s_srst, s_txd, s_rxa, s_rxd;
      trace_step_t st;
      total_cycles = 0;
      fd = $fopen("sim/pcie_rst_trace.txt", "r");
      if (fd == 0) begin
         $display("could not open the trace file sim/pcie_rst_trace.txt");
         errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            // skip comments and blank lines
            if (line.len() < 2 || line[0] == "#") begin
               continue;
            end
            n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %s %s %s %s %s",
                        hold_v, c_pll, c_rxpll, c_freq, c_txcal, c_rxcal, c_fifo,
                        c_ltssm, c_dlup, c_hot, c_l2, c_flick,
                        s_crst, s_srst, s_txd, s_rxa, s_rxd);
            if (n != 17) begin
               $display("malformed trace line: %s", line);
               errors++;
               continue;
            end
            st.hold          = hold_v;
            st.pll_locked    = c_pll[0];
            st.rx_pll_locked = c_rxpll[lane_count-1:0];
            st.rx_freqlocked = c_freq[lane_count-1:0];
            st.tx_cal_busy   = c_txcal[0];
            st.rx_cal_busy   = c_rxcal[0];
            st.fifo_err      = c_fifo[0];
            st.ltssm         = c_ltssm[4:0];
            st.dlup_exit     = c_dlup[0];
            st.hotrst_exit   = c_hot[0];
            st.l2_exit       = c_l2[0];
            st.flicker       = c_flick[0];
            st.exp_crst      = s_crst;
            st.exp_srst      = s_srst;
            st.exp_txd       = s_txd;
            st.exp_rxa       = s_rxa;
            st.exp_rxd       = s_rxd;
            steps.push_back(st);
            total_cycles += hold_v;
         end
         $fclose(fd);
         if (steps.size() == 0) begin
            $display("the trace file held no steps");
            errors++;
         end
      end
   endtask

   task automatic check_output(input string name, input logic [7:0] exp_chr,
                               input logic actual);
      logic exp_bit;
      if (exp_chr != "-") begin
         exp_bit = (exp_chr == "1");
         checks++;
         assert (actual === exp_bit) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s expected %0b actual %0b",
                     $time, name, exp_bit, actual);
         end
      end
   endtask

   task automatic drive_inputs(input trace_step_t st);
      pll_locked    = st.pll_locked;
      rx_pll_locked = st.rx_pll_locked;
      rx_freqlocked = st.rx_freqlocked;
      tx_cal_busy   = st.tx_cal_busy;
      rx_cal_busy   = st.rx_cal_busy;
      fifo_err      = st.fifo_err;
      ltssm         = st.ltssm;
      dlup_exit     = st.dlup_exit;
      hotrst_exit   = st.hotrst_exit;
      l2_exit       = st.l2_exit;
   endtask

   // hold one trace step, optionally with lane flicker, then compare the outputs
   task automatic run_step(input trace_step_t st);
      int unsigned cyc;
      int unsigned low_run;
      lane_vec_t   mask;
      drive_inputs(st);
      low_run = 0;
      for (cyc = 0; cyc < st.hold; cyc++) begin
         @(negedge pld_clk);
         if (st.flicker) begin
            check_output("rxdigitalreset", st.exp_rxd, rxdigitalreset);
            // dropouts last at most 4 cycles, well inside the 7-cycle hysteresis
            if (cyc + 1 == st.hold) begin
               rx_freqlocked = st.rx_freqlocked;
            end else if (low_run < 4 && ($urandom & 1) != 0) begin
               mask = lane_vec_t'($urandom);
               mask[$urandom_range(lane_count-1, 0)] = 1'b0;
               rx_freqlocked = st.rx_freqlocked & mask;
               low_run++;
            end else begin
               rx_freqlocked = st.rx_freqlocked;
               low_run = 0;
            end
         end
      end
      check_output("crst", st.exp_crst, crst);
      check_output("srst", st.exp_srst, srst);
      check_output("txdigitalreset", st.exp_txd, txdigitalreset);
      check_output("rxanalogreset", st.exp_rxa, rxanalogreset);
      check_output("rxdigitalreset", st.exp_rxd, rxdigitalreset);
   endtask

   initial begin
      arst          = 1'b1;
      pll_locked    = 1'b0;
      rx_pll_locked = '0;
      rx_freqlocked = '0;
      tx_cal_busy   = 1'b0;
      rx_cal_busy   = 1'b0;
      fifo_err      = 1'b0;
      ltssm         = ltssm_detect_quiet;
      dlup_exit     = 1'b1;
      hotrst_exit   = 1'b1;
      l2_exit       = 1'b1;
      checks        = 0;
      errors        = 0;
      void'($urandom(94));
      load_trace();
      trace_loaded = 1'b1;

      repeat (16) @(negedge pld_clk);
      arst = 1'b0;

      foreach (steps[i]) begin
         run_step(steps[i]);
      end

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
